/* Bender.yml */
package:
  name: msp430Exec

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/msp430Pkg.sv
      - hdl/opQueue.sv
      - hdl/functionUnit.sv
      - hdl/execCore.sv
      - hdl/msp430Exec.sv
  - target: simulation
    include_dirs:
      - hdl
      - sim
    files:
      - sim/msp430ExecTb.sv

/* hdl/execCore.sv */
// Execute control with status register, result register and write-back credits
`timescale 1ns/100ps
`include "msp430Exec_config.svh"

module execCore (
    input  logic             clk,
    input  logic             reset,
    input  logic             headValid,
    input  msp430Pkg::instrT headIw,
    input  msp430Pkg::wordT  fuResult,
    input  logic             zNew,
    input  logic             vNew,
    input  logic             nNew,
    input  logic             cNew,
    input  logic             resultCredit,
    output logic             pop,
    output logic             zFlag,
    output logic             vFlag,
    output logic             nFlag,
    output logic             cFlag,
    output msp430Pkg::wordT  result,
    output logic             resultValid,
    output logic             writeDst
);

    localparam int CreditW = $clog2(`EXEC_OUT_CREDITS + 1);

    logic [CreditW-1:0] outCredits;
    logic               isJump;
    logic               isTestOnly;
    logic               dstWrite;

    // Issue only with a valid head and room downstream
    assign pop = headValid && (outCredits != '0);

    assign isJump     = (headIw[15:13] == 3'b001);
    assign isTestOnly = ({headIw[15:12], 12'h000} == msp430Pkg::CMP) ||
                        ({headIw[15:12], 12'h000} == msp430Pkg::BIT);

    // Taken jumps write the PC and fall-through leaves it alone
    assign dstWrite = !isTestOnly &&
                      !(isJump && !msp430Pkg::jumpTaken(headIw, zFlag, vFlag, nFlag, cFlag));

    always_ff @(posedge clk) begin
        if (reset) begin
            outCredits <= CreditW'(`EXEC_OUT_CREDITS);
        end else begin
            case ({resultCredit, pop})
                2'b10:   outCredits <= outCredits + 1'b1;
                2'b01:   outCredits <= outCredits - 1'b1;
                default: outCredits <= outCredits;  // Returned and spent cancel out
            endcase
        end
    end

    // Status bits load on each pop for the next op to see
    always_ff @(posedge clk) begin
        if (reset) begin
            {zFlag, vFlag, nFlag, cFlag} <= 4'b0000;
        end else if (pop) begin
            {zFlag, vFlag, nFlag, cFlag} <= {zNew, vNew, nNew, cNew};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) resultValid <= 1'b0;
        else       resultValid <= pop;
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            result   <= fuResult;
            writeDst <= dstWrite;
        end
    end

endmodule

/* hdl/functionUnit.sv */
// MSP430 ALU for word and byte format I, format II and jump instructions
`timescale 1ns/100ps
`include "msp430Exec_config.svh"

module functionUnit (
    input  msp430Pkg::instrT iw,
    input  msp430Pkg::wordT  src,
    input  msp430Pkg::wordT  dst,
    input  logic             zIn,
    input  logic             vIn,
    input  logic             nIn,
    input  logic             cIn,
    output msp430Pkg::wordT  result,
    output logic             zOut,
    output logic             vOut,
    output logic             nOut,
    output logic             cOut
);

    msp430Pkg::instrT fmtIOp, fmtIIOp;
    msp430Pkg::byteT  srcLow, dstLow;
    msp430Pkg::wordT  addOperand;   // src or ~src for the subtract group
    msp430Pkg::wordT  jumpTarget;
    msp430Pkg::wordT  daddResult;
    logic             isByte;
    logic             addCin;
    logic [16:0]      wordSum;
    logic [8:0]       byteSum;
    logic             wordOvf, byteOvf;
    logic [4:0]       digitSum;
    logic             daddCarry;
    logic             updZN;        // Z and N follow the result

    assign fmtIOp  = {iw[15:12], 12'h000};
    assign fmtIIOp = {iw[15:7], 7'h00};
    assign isByte  = iw[6];
    assign srcLow  = src[7:0];
    assign dstLow  = dst[7:0];

    // PC plus twice the sign-extended 10-bit offset
    assign jumpTarget = dst + {{5{iw[9]}}, iw[9:0], 1'b0};

    always_comb begin
        addOperand = src;
        addCin     = 1'b0;
        case (fmtIOp)
            msp430Pkg::ADDC: addCin = cIn;
            msp430Pkg::SUBC: begin
                addOperand = ~src;
                addCin     = cIn;
            end
            msp430Pkg::SUB, msp430Pkg::CMP: begin
                addOperand = ~src;        // Two's complement with the forced carry
                addCin     = 1'b1;
            end
            default: addCin = 1'b0;
        endcase
    end

    // 17-bit and 9-bit sums give the carry straight from the top bit
    assign wordSum = {1'b0, dst} + {1'b0, addOperand} + {16'h0000, addCin};
    assign byteSum = {1'b0, dstLow} + {1'b0, addOperand[7:0]} + {8'h00, addCin};
    assign wordOvf = (dst[15] == addOperand[15]) && (wordSum[15] != dst[15]);
    assign byteOvf = (dstLow[7] == addOperand[7]) && (byteSum[7] != dstLow[7]);

    // Decimal add one BCD digit at a time with the carry rippling upward
    always_comb begin
        daddCarry  = cIn;
        daddResult = '0;
        digitSum   = '0;
        for (int d = 0; d < 4; d++) begin
            if (!isByte || d < 2) begin
                digitSum = {1'b0, dst[4*d +: 4]} + {1'b0, src[4*d +: 4]} + {4'h0, daddCarry};
                if (digitSum > 5'd9) begin
                    daddResult[4*d +: 4] = digitSum[3:0] + 4'd6;
                    daddCarry = 1'b1;
                end else begin
                    daddResult[4*d +: 4] = digitSum[3:0];
                    daddCarry = 1'b0;
                end
            end
        end
    end

    always_comb begin
        {zOut, vOut, nOut, cOut} = {zIn, vIn, nIn, cIn};  // Undefined flags hold
        result = '0;                                      // High byte stays clear for .B
        updZN  = 1'b0;

        if (iw[15:13] == 3'b001) begin
            result = msp430Pkg::jumpTaken(iw, zIn, vIn, nIn, cIn) ? jumpTarget : dst;
        end else if (iw[15:12] == 4'h1) begin
            case (fmtIIOp)
                msp430Pkg::RRC: begin
                    result = isByte ? {8'h00, cIn, dstLow[7:1]} : {cIn, dst[15:1]};
                    cOut   = dst[0];
                    vOut   = 1'b0;
                    updZN  = 1'b1;
                end
                msp430Pkg::SWPB: begin
                    result = isByte ? `EXEC_ILLEGAL_RESULT : {dstLow, dst[15:8]};
                end
                msp430Pkg::RRA: begin
                    result = isByte ? {8'h00, dstLow[7], dstLow[7:1]} : {dst[15], dst[15:1]};
                    cOut   = dst[0];
                    vOut   = 1'b0;
                    updZN  = 1'b1;
                end
                msp430Pkg::SXT: begin
                    if (isByte) begin
                        result = `EXEC_ILLEGAL_RESULT;
                    end else begin
                        result = {{8{dstLow[7]}}, dstLow};
                        cOut   = (result != '0);
                        vOut   = 1'b0;
                        updZN  = 1'b1;
                    end
                end
                msp430Pkg::PUSH: result = isByte ? {8'h00, dstLow} : dst;
                msp430Pkg::CALL: result = isByte ? `EXEC_ILLEGAL_RESULT : dst;  // Return PC
                msp430Pkg::RETI: result = isByte ? `EXEC_ILLEGAL_RESULT : src;  // Popped word
                default:         result = `EXEC_ILLEGAL_RESULT;
            endcase
        end else begin
            case (fmtIOp)
                msp430Pkg::MOV: result = isByte ? {8'h00, srcLow} : src;
                msp430Pkg::ADD, msp430Pkg::ADDC, msp430Pkg::SUBC,
                msp430Pkg::SUB, msp430Pkg::CMP: begin
                    result = isByte ? {8'h00, byteSum[7:0]} : wordSum[15:0];
                    cOut   = isByte ? byteSum[8] : wordSum[16];
                    vOut   = isByte ? byteOvf : wordOvf;
                    updZN  = 1'b1;
                end
                msp430Pkg::DADD: begin
                    result = daddResult;
                    cOut   = daddCarry;
                    updZN  = 1'b1;
                end
                msp430Pkg::BIT, msp430Pkg::AND: begin
                    result = isByte ? {8'h00, srcLow & dstLow} : src & dst;
                    cOut   = (result != '0);
                    vOut   = 1'b0;
                    updZN  = 1'b1;
                end
                msp430Pkg::BIC: result = isByte ? {8'h00, ~srcLow & dstLow} : ~src & dst;
                msp430Pkg::BIS: result = isByte ? {8'h00, srcLow | dstLow} : src | dst;
                msp430Pkg::XOR: begin
                    result = isByte ? {8'h00, srcLow ^ dstLow} : src ^ dst;
                    cOut   = (result != '0);
                    // Overflow when both operands are negative
                    vOut   = isByte ? (srcLow[7] & dstLow[7]) : (src[15] & dst[15]);
                    updZN  = 1'b1;
                end
                default: result = `EXEC_ILLEGAL_RESULT;
            endcase
        end

        if (updZN) begin
            zOut = (result == '0);
            nOut = isByte ? result[7] : result[15];
        end
    end

endmodule

/* hdl/msp430Exec.sv */
// Execute slice top joining the operation queue, ALU and execute control
`timescale 1ns/100ps

module msp430Exec (
    input  logic             clk,
    input  logic             reset,
    input  logic             opValid,
    input  msp430Pkg::instrT iw,
    input  msp430Pkg::wordT  src,
    input  msp430Pkg::wordT  dst,
    output logic             opCredit,
    input  logic             resultCredit,
    output msp430Pkg::wordT  result,
    output logic             resultValid,
    output logic             writeDst,
    output logic             zFlag,
    output logic             vFlag,
    output logic             nFlag,
    output logic             cFlag
);

    logic             headValid;
    msp430Pkg::instrT headIw;
    msp430Pkg::wordT  headSrc, headDst;
    logic             pop;
    msp430Pkg::wordT  fuResult;
    logic             zNew, vNew, nNew, cNew;

    opQueue u_queue (
        .clk       (clk),
        .reset     (reset),
        .opValid   (opValid),
        .iw        (iw),
        .src       (src),
        .dst       (dst),
        .pop       (pop),
        .headValid (headValid),
        .headIw    (headIw),
        .headSrc   (headSrc),
        .headDst   (headDst),
        .opCredit  (opCredit)
    );

    functionUnit u_fu (
        .iw     (headIw),
        .src    (headSrc),
        .dst    (headDst),
        .zIn    (zFlag),
        .vIn    (vFlag),
        .nIn    (nFlag),
        .cIn    (cFlag),
        .result (fuResult),
        .zOut   (zNew),
        .vOut   (vNew),
        .nOut   (nNew),
        .cOut   (cNew)
    );

    execCore u_core (
        .clk          (clk),
        .reset        (reset),
        .headValid    (headValid),
        .headIw       (headIw),
        .fuResult     (fuResult),
        .zNew         (zNew),
        .vNew         (vNew),
        .nNew         (nNew),
        .cNew         (cNew),
        .resultCredit (resultCredit),
        .pop          (pop),
        .zFlag        (zFlag),
        .vFlag        (vFlag),
        .nFlag        (nFlag),
        .cFlag        (cFlag),
        .result       (result),
        .resultValid  (resultValid),
        .writeDst     (writeDst)
    );

endmodule

/* hdl/msp430Exec_config.svh */
// Build-time sizing and constants for the MSP430 execute slice
`ifndef MSP430_EXEC_CONFIG_SVH
`define MSP430_EXEC_CONFIG_SVH

// Operation queue entries
// The upstream stage starts with this many credits
`define EXEC_QUEUE_DEPTH 4

// Results that may be outstanding toward write-back before a credit returns
`define EXEC_OUT_CREDITS 2

// Result word for an instruction that does not decode
`define EXEC_ILLEGAL_RESULT 16'hDEAD

`endif

/* hdl/msp430Pkg.sv */
// Shared MSP430 execute types, opcode patterns and the jump condition decode
package msp430Pkg;

    typedef logic [15:0] wordT;   // Operand and result data
    typedef logic [7:0]  byteT;   // Low half of a word for .B operations
    typedef logic [15:0] instrT;  // Raw instruction word

    typedef enum logic [1:0] {
        queueEmpty,
        queuePartial,
        queueFull
    } queueStateT;

    // Format I patterns matched on {iw[15:12], 12'h000}
    localparam instrT MOV  = 16'h4000;
    localparam instrT ADD  = 16'h5000;
    localparam instrT ADDC = 16'h6000;
    localparam instrT SUBC = 16'h7000;
    localparam instrT SUB  = 16'h8000;
    localparam instrT CMP  = 16'h9000;
    localparam instrT DADD = 16'hA000;
    localparam instrT BIT  = 16'hB000;
    localparam instrT BIC  = 16'hC000;
    localparam instrT BIS  = 16'hD000;
    localparam instrT XOR  = 16'hE000;
    localparam instrT AND  = 16'hF000;

    // Format II patterns matched on {iw[15:7], 7'h00}
    localparam instrT RRC  = 16'h1000;
    localparam instrT SWPB = 16'h1080;
    localparam instrT RRA  = 16'h1100;
    localparam instrT SXT  = 16'h1180;
    localparam instrT PUSH = 16'h1200;
    localparam instrT CALL = 16'h1280;
    localparam instrT RETI = 16'h1300;

    // Jump patterns matched on {iw[15:10], 10'h000}
    localparam instrT JNE  = 16'h2000;
    localparam instrT JEQ  = 16'h2400;
    localparam instrT JNC  = 16'h2800;
    localparam instrT JC   = 16'h2C00;
    localparam instrT JN   = 16'h3000;
    localparam instrT JGE  = 16'h3400;
    localparam instrT JL   = 16'h3800;
    localparam instrT JMP  = 16'h3C00;

    // Branch condition for a jump word against the current status bits
    function automatic logic jumpTaken(instrT iw, logic z, logic v, logic n, logic c);
        case ({iw[15:10], 10'h000})
            JNE:     jumpTaken = ~z;
            JEQ:     jumpTaken = z;
            JNC:     jumpTaken = ~c;
            JC:      jumpTaken = c;
            JN:      jumpTaken = n;
            JGE:     jumpTaken = ~(n ^ v);
            JL:      jumpTaken = n ^ v;
            JMP:     jumpTaken = 1'b1;
            default: jumpTaken = 1'b0;
        endcase
    endfunction

endpackage

/* hdl/opQueue.sv */
// Credit-fed circular operation queue holding instruction words and operands
`timescale 1ns/100ps
`include "msp430Exec_config.svh"

module opQueue (
    input  logic               clk,
    input  logic               reset,
    input  logic               opValid,
    input  msp430Pkg::instrT   iw,
    input  msp430Pkg::wordT    src,
    input  msp430Pkg::wordT    dst,
    input  logic               pop,
    output logic               headValid,
    output msp430Pkg::instrT   headIw,
    output msp430Pkg::wordT    headSrc,
    output msp430Pkg::wordT    headDst,
    output logic               opCredit
);

    localparam int Depth = `EXEC_QUEUE_DEPTH;
    localparam int PtrW  = (Depth > 1) ? $clog2(Depth) : 1;

    msp430Pkg::instrT iwMem  [Depth];
    msp430Pkg::wordT  srcMem [Depth];
    msp430Pkg::wordT  dstMem [Depth];

    logic [PtrW-1:0] wrPtr, rdPtr;
    logic [PtrW-1:0] wrPtrNext, rdPtrNext;
    msp430Pkg::queueStateT state;
    logic doPop;

    // Upstream credits guarantee space so opValid is never refused
    assign doPop = pop && headValid;

    assign wrPtrNext = (wrPtr == PtrW'(Depth - 1)) ? '0 : wrPtr + 1'b1;
    assign rdPtrNext = (rdPtr == PtrW'(Depth - 1)) ? '0 : rdPtr + 1'b1;

    always_ff @(posedge clk) begin
        if (opValid) begin
            iwMem[wrPtr]  <= iw;
            srcMem[wrPtr] <= src;
            dstMem[wrPtr] <= dst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            state <= msp430Pkg::queueEmpty;
        end else begin
            if (opValid) wrPtr <= wrPtrNext;
            if (doPop) rdPtr <= rdPtrNext;
            // Occupancy only moves when exactly one side is active
            if (opValid && !doPop) begin
                state <= (wrPtrNext == rdPtr) ? msp430Pkg::queueFull : msp430Pkg::queuePartial;
            end else if (doPop && !opValid) begin
                state <= (rdPtrNext == wrPtr) ? msp430Pkg::queueEmpty : msp430Pkg::queuePartial;
            end
        end
    end

    // One credit back upstream per freed entry
    always_ff @(posedge clk) begin
        if (reset) opCredit <= 1'b0;
        else       opCredit <= doPop;
    end

    assign headValid = (state != msp430Pkg::queueEmpty);
    assign headIw    = iwMem[rdPtr];
    assign headSrc   = srcMem[rdPtr];
    assign headDst   = dstMem[rdPtr];

endmodule

/* msp430Exec.f */
+incdir+hdl
+incdir+sim
hdl/msp430Pkg.sv
hdl/opQueue.sv
hdl/functionUnit.sv
hdl/execCore.sv
hdl/msp430Exec.sv
sim/msp430ExecTb.sv

/* sim/msp430Model.svh */
// Reference model of MSP430 execute semantics and status flag rules for the testbench
`ifndef MSP430_MODEL_SVH
`define MSP430_MODEL_SVH

`include "msp430Exec_config.svh"

logic mZ = 1'b0;   // Model status register
logic mV = 1'b0;
logic mN = 1'b0;
logic mC = 1'b0;

task automatic modelExecute(input msp430Pkg::instrT iw, input msp430Pkg::wordT s,
                            input msp430Pkg::wordT d, output msp430Pkg::wordT r,
                            output logic wr);
    int w, half, mask, sVal, dVal, sSig, dSig, sumU, sumS, off, dig, bin, carry;
    logic byteOp, setZN, taken;
    byteOp = iw[6];
    w      = byteOp ? 8 : 16;
    half   = 1 << (w - 1);
    mask   = (1 << w) - 1;
    sVal   = int'(s) & mask;
    dVal   = int'(d) & mask;
    sSig   = (sVal >= half) ? sVal - 2 * half : sVal;
    dSig   = (dVal >= half) ? dVal - 2 * half : dVal;
    r      = `EXEC_ILLEGAL_RESULT;
    wr     = 1'b1;
    setZN  = 1'b0;
    if (iw[15:13] == 3'b001) begin
        case (iw[12:10])
            3'd0: taken = !mZ;
            3'd1: taken = mZ;
            3'd2: taken = !mC;
            3'd3: taken = mC;
            3'd4: taken = mN;
            3'd5: taken = (mN == mV);
            3'd6: taken = (mN != mV);
            default: taken = 1'b1;
        endcase
        off = iw[9] ? int'(iw[9:0]) - 1024 : int'(iw[9:0]);  // Signed word offset
        r   = taken ? 16'(int'(d) + 2 * off) : d;
        wr  = taken;
    end else if (iw[15:12] == 4'h1) begin
        case ({iw[15:7], 7'h00})
            msp430Pkg::RRC: begin
                r  = 16'((dVal >> 1) + (int'(mC) << (w - 1)));
                mC = d[0];
                mV = 1'b0;
                setZN = 1'b1;
            end
            msp430Pkg::RRA: begin
                r  = 16'((dVal >> 1) + (dVal & half));  // Sign bit stays put
                mC = d[0];
                mV = 1'b0;
                setZN = 1'b1;
            end
            msp430Pkg::SWPB: if (!byteOp) r = {d[7:0], d[15:8]};
            msp430Pkg::SXT: if (!byteOp) begin
                r  = d[7] ? (d | 16'hFF00) : (d & 16'h00FF);
                mC = (r != 16'h0000);
                mV = 1'b0;
                setZN = 1'b1;
            end
            msp430Pkg::PUSH: r = 16'(dVal);
            msp430Pkg::CALL: if (!byteOp) r = d;
            msp430Pkg::RETI: if (!byteOp) r = s;
            default: r = `EXEC_ILLEGAL_RESULT;
        endcase
    end else begin
        case ({iw[15:12], 12'h000})
            msp430Pkg::MOV: r = 16'(sVal);
            msp430Pkg::ADD, msp430Pkg::ADDC: begin
                carry = ({iw[15:12], 12'h000} == msp430Pkg::ADDC) ? int'(mC) : 0;
                sumU  = dVal + sVal + carry;
                sumS  = dSig + sSig + carry;
                r     = 16'(sumU & mask);
                mC    = (sumU > mask);
                mV    = (sumS >= half) || (sumS < -half);
                setZN = 1'b1;
            end
            msp430Pkg::SUB, msp430Pkg::SUBC, msp430Pkg::CMP: begin
                bin   = ({iw[15:12], 12'h000} == msp430Pkg::SUBC) ? 1 - int'(mC) : 0;
                sumU  = dVal - sVal - bin;   // Carry set means no borrow
                sumS  = dSig - sSig - bin;
                r     = 16'(sumU & mask);
                mC    = (sumU >= 0);
                mV    = (sumS >= half) || (sumS < -half);
                setZN = 1'b1;
                wr    = ({iw[15:12], 12'h000} != msp430Pkg::CMP);
            end
            msp430Pkg::DADD: begin
                carry = int'(mC);
                r     = 16'h0000;
                for (int i = 0; i < w / 4; i++) begin
                    dig = ((dVal >> (4 * i)) & 15) + ((sVal >> (4 * i)) & 15) + carry;
                    carry = (dig > 9) ? 1 : 0;
                    if (dig > 9) dig = dig - 10;
                    r = r | 16'((dig & 15) << (4 * i));
                end
                mC    = carry[0];
                setZN = 1'b1;
            end
            msp430Pkg::AND, msp430Pkg::BIT: begin
                r     = 16'(sVal & dVal);
                mC    = (r != 16'h0000);
                mV    = 1'b0;
                setZN = 1'b1;
                wr    = ({iw[15:12], 12'h000} != msp430Pkg::BIT);
            end
            msp430Pkg::BIC: r = 16'(~sVal & dVal);
            msp430Pkg::BIS: r = 16'(sVal | dVal);
            msp430Pkg::XOR: begin
                r     = 16'(sVal ^ dVal);
                mC    = (r != 16'h0000);
                mV    = (sSig < 0) && (dSig < 0);
                setZN = 1'b1;
            end
            default: r = `EXEC_ILLEGAL_RESULT;
        endcase
    end
    if (setZN) begin
        mZ = (r == 16'h0000);
        mN = byteOp ? r[7] : r[15];
    end
endtask

`endif

/* sim/msp430ExecTb.sv */
// Random credit-driven testbench for the MSP430 execute slice against a reference model
`timescale 1ns/100ps
`include "msp430Exec_config.svh"

module msp430ExecTb;

    localparam int ClkPeriod   = 20;
    localparam int ResetCycles = 8;
    localparam int NumOps      = 400;

    logic             clk;
    logic             reset;
    logic             opValid;
    msp430Pkg::instrT iw;
    msp430Pkg::wordT  src, dst;
    logic             opCredit;
    logic             resultCredit;
    msp430Pkg::wordT  result;
    logic             resultValid, writeDst;
    logic             zFlag, vFlag, nFlag, cFlag;

    logic [31:0] lfsrState = 32'h3833_9785;
    int upCredits   = `EXEC_QUEUE_DEPTH;   // Upstream view of queue space
    int outCredits  = `EXEC_OUT_CREDITS;   // Write-back credits granted and unused
    int heldCredits = 0;                   // Results not yet credited back
    int sentCount   = 0;
    int doneCount   = 0;
    int valueErrors = 0;
    int protoErrors = 0;

    msp430Pkg::instrT sentIw[$];
    msp430Pkg::wordT  sentSrc[$];
    msp430Pkg::wordT  sentDst[$];

    `include "msp430Model.svh"

    msp430Exec u_dut (
        .clk          (clk),
        .reset        (reset),
        .opValid      (opValid),
        .iw           (iw),
        .src          (src),
        .dst          (dst),
        .opCredit     (opCredit),
        .resultCredit (resultCredit),
        .result       (result),
        .resultValid  (resultValid),
        .writeDst     (writeDst),
        .zFlag        (zFlag),
        .vFlag        (vFlag),
        .nFlag        (nFlag),
        .cFlag        (cFlag)
    );

    // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic [31:0] takeBits(int n);
        logic [31:0] bits;
        logic        fb;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            bits      = {bits[30:0], fb};
        end
        return bits;
    endfunction

    // Weighted opcode table with arithmetic drawn more often than the rest
    function automatic msp430Pkg::instrT pickOpcode(logic [4:0] k);
        case (k)
            0, 1, 2:    return msp430Pkg::ADD;
            3, 4:       return msp430Pkg::ADDC;
            5, 6:       return msp430Pkg::SUB;
            7, 8:       return msp430Pkg::SUBC;
            9, 10:      return msp430Pkg::CMP;
            11, 12:     return msp430Pkg::DADD;
            13:         return msp430Pkg::AND;
            14:         return msp430Pkg::BIT;
            15:         return msp430Pkg::BIC;
            16:         return msp430Pkg::BIS;
            17:         return msp430Pkg::XOR;
            18:         return msp430Pkg::MOV;
            19:         return msp430Pkg::RRC;
            20:         return msp430Pkg::RRA;
            21:         return msp430Pkg::SWPB;
            22:         return msp430Pkg::SXT;
            23:         return msp430Pkg::PUSH;
            24:         return msp430Pkg::CALL;
            25:         return msp430Pkg::RETI;
            26, 27, 28: return msp430Pkg::JMP;   // Condition drawn separately
            29:         return 16'h1380;           // Unused format II slot
            default:    return 16'h0000;           // Undecoded group
        endcase
    endfunction

    function automatic msp430Pkg::wordT toBcd(msp430Pkg::wordT v);
        msp430Pkg::wordT b;
        for (int i = 0; i < 4; i++) b[4*i +: 4] = v[4*i +: 4] % 4'd10;
        return b;
    endfunction

    task automatic makeRandomOp(output msp430Pkg::instrT w, output msp430Pkg::wordT s,
                                output msp430Pkg::wordT d);
        msp430Pkg::instrT base;
        base = pickOpcode(5'(takeBits(5)));
        if (base[15:13] == 3'b001)   w = {base[15:13], 13'(takeBits(13))};
        else if (base[15:12] == 4'h1) w = {base[15:7], 7'(takeBits(7))};
        else                          w = {base[15:12], 12'(takeBits(12))};
        s = 16'(takeBits(16));
        d = 16'(takeBits(16));
        if (3'(takeBits(3)) == 3'd0) s = d;   // Equal operands reach Z and no-borrow cases
        if ({w[15:12], 12'h000} == msp430Pkg::DADD) begin
            s = toBcd(s);
            d = toBcd(d);
        end
    endtask

    task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
        assert (expected === actual) else begin
            $display("ERR %0t %s expected %h got %h", $time, name, expected, actual);
            valueErrors++;
        end
    endtask

    task automatic reportFailure(string what);
        $display("At %0t the testbench found %s", $time, what);
        protoErrors++;
    endtask

    task automatic checkResult();
        msp430Pkg::instrT expIw;
        msp430Pkg::wordT  expSrc, expDst, expRes;
        logic             expWr;
        assert (outCredits > 0) else reportFailure("a result without a write-back credit");
        outCredits--;
        heldCredits++;
        assert (sentIw.size() > 0) else reportFailure("a result with no op outstanding");
        if (sentIw.size() > 0) begin
            expIw  = sentIw.pop_front();
            expSrc = sentSrc.pop_front();
            expDst = sentDst.pop_front();
            modelExecute(expIw, expSrc, expDst, expRes, expWr);
            checkValue("result", expRes, result);
            checkValue("writeDst", 16'(expWr), 16'(writeDst));
            checkValue("zFlag", 16'(mZ), 16'(zFlag));
            checkValue("vFlag", 16'(mV), 16'(vFlag));
            checkValue("nFlag", 16'(mN), 16'(nFlag));
            checkValue("cFlag", 16'(mC), 16'(cFlag));
            doneCount++;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // Credit returns and results counted on the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (opCredit) upCredits++;
            assert (upCredits >= 0 && upCredits <= `EXEC_QUEUE_DEPTH)
                else reportFailure("the upstream credit count out of range");
            if (resultValid) checkResult();
        end
    end

    initial begin : stimulus
        msp430Pkg::instrT newIw;
        msp430Pkg::wordT  newSrc, newDst;
        logic [1:0]       sendRoll;
        logic [2:0]       creditRoll;
        reset        = 1'b1;
        opValid      = 1'b0;
        iw           = '0;
        src          = '0;
        dst          = '0;
        resultCredit = 1'b0;
        repeat (ResetCycles) @(posedge clk);
        reset <= 1'b0;
        while (doneCount < NumOps) begin
            @(posedge clk);
            opValid      <= 1'b0;
            resultCredit <= 1'b0;
            sendRoll   = 2'(takeBits(2));
            creditRoll = 3'(takeBits(3));
            if (sentCount < NumOps && upCredits > 0 && sendRoll != 2'd0) begin
                makeRandomOp(newIw, newSrc, newDst);
                opValid <= 1'b1;
                iw      <= newIw;
                src     <= newSrc;
                dst     <= newDst;
                sentIw.push_back(newIw);
                sentSrc.push_back(newSrc);
                sentDst.push_back(newDst);
                upCredits--;
                sentCount++;
            end
            if (heldCredits > 0 && creditRoll < 3'd3) begin   // Withhold most of the time
                resultCredit <= 1'b1;
                heldCredits--;
                outCredits++;
            end
        end
        @(posedge clk);
        assert (upCredits == `EXEC_QUEUE_DEPTH)
            else reportFailure("upstream credits missing after the last op");
        $display("Checked %0d results, value errors %0d, protocol errors %0d",
                 doneCount, valueErrors, protoErrors);
        if (valueErrors == 0 && protoErrors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        #((NumOps * 40 + ResetCycles) * ClkPeriod);
        $display("Watchdog expired with %0d of %0d ops complete", doneCount, NumOps);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule
